// ==== common/cpu_pkg.sv ====
// ####################
// shared widths, word types, opcodes, ALU codes and start address
// ####################
`default_nettype none

package cpu_pkg;

    localparam int ADDR_W  = 6;
    localparam int WORD_W  = 16;
    localparam int FIELD_W = 3;

    // memory address and data word
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;

    // instruction fields
    typedef logic [3:0]         opcode_t;
    typedef logic [FIELD_W-1:0] field_t;

    typedef logic [1:0]         alu_op_t;

    // opcodes, anything else runs as a no-op
    localparam opcode_t OP_MOV  = 4'd0;
    localparam opcode_t OP_ADD  = 4'd1;
    localparam opcode_t OP_SUB  = 4'd2;
    localparam opcode_t OP_MUL  = 4'd3;
    localparam opcode_t OP_IN   = 4'd7;
    localparam opcode_t OP_OUT  = 4'd8;
    localparam opcode_t OP_STOP = 4'd15;

    localparam alu_op_t ALU_ADD = 2'd0;
    localparam alu_op_t ALU_SUB = 2'd1;
    localparam alu_op_t ALU_MUL = 2'd2;

    // first instruction lives above the data words
    localparam addr_t PC_START = 6'd8;

endpackage

`default_nettype wire

// ==== logic/alu.sv ====
// ####################
// combinational add, subtract, multiply
// ####################
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_t alu_op,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    output cpu_pkg::word_t        result
);

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: result = a + b;
            cpu_pkg::ALU_SUB: result = a - b;
            // product truncated to the low word
            cpu_pkg::ALU_MUL: result = a * b;
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/io_port.sv ====
// ####################
// four-phase req/ack sequencer for input and output channels
// ####################
`default_nettype none

module io_port (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 io_start,
    input  wire                 io_dir,
    input  wire cpu_pkg::word_t io_wdata,
    input  wire                 in_ack,
    input  wire cpu_pkg::word_t in_data,
    input  wire                 out_ack,
    output logic                io_done,
    output cpu_pkg::word_t      io_rdata,
    output logic                in_req,
    output logic                out_req,
    output cpu_pkg::word_t      out_data
);

    typedef enum logic [1:0] {
        IO_IDLE,
        IO_REQ,
        IO_REL,
        IO_DONE
    } io_state_t;

    io_state_t state;

    // 0 = input channel, 1 = output channel
    logic      dir_reg;
    logic      ack;

    assign ack     = dir_reg ? out_ack : in_ack;
    assign in_req  = (state == IO_REQ) && !dir_reg;
    assign out_req = (state == IO_REQ) && dir_reg;
    assign io_done = (state == IO_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IO_IDLE;
            dir_reg <= 1'b0;
        end else begin
            case (state)
                IO_IDLE: begin
                    if (io_start) begin
                        dir_reg <= io_dir;
                        state   <= IO_REQ;
                    end
                end
                IO_REQ: begin
                    if (ack) begin
                        state <= IO_REL;
                    end
                end
                // partner must drop ack before we finish
                IO_REL: begin
                    if (!ack) begin
                        state <= IO_DONE;
                    end
                end
                default: state <= IO_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IO_IDLE && io_start && io_dir) begin
            out_data <= io_wdata;
        end
        if (state == IO_REQ && !dir_reg && in_ack) begin
            io_rdata <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== cpu/cpu_control.sv ====
// ####################
// control unit: PC, IR, decode and multicycle execute FSM
// ####################
`default_nettype none

module cpu_control (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire cpu_pkg::word_t mem_rdata,
    input  wire cpu_pkg::word_t alu_result,
    input  wire                 io_done,
    input  wire cpu_pkg::word_t io_rdata,
    output cpu_pkg::addr_t      mem_addr,
    output cpu_pkg::word_t      mem_wdata,
    output logic                mem_we,
    output cpu_pkg::alu_op_t    alu_op,
    output cpu_pkg::word_t      alu_a,
    output cpu_pkg::word_t      alu_b,
    output logic                io_start,
    output logic                io_dir,
    output cpu_pkg::word_t      io_wdata,
    output cpu_pkg::addr_t      pc,
    output logic                halted
);

    typedef enum logic [3:0] {
        S_START,
        S_FETCH,
        S_DECODE,
        S_OP_DIR,
        S_OP_IND,
        S_OP_CAP,
        S_EXEC,
        S_IO_START,
        S_IO_WAIT,
        S_TGT,
        S_WB,
        S_STOP
    } state_t;

    state_t           state;
    state_t           state_next;

    cpu_pkg::addr_t   pc_reg;
    cpu_pkg::word_t   ir_reg;
    cpu_pkg::word_t   src_a_reg;
    cpu_pkg::word_t   src_b_reg;
    cpu_pkg::word_t   acc_reg;

    // which operand is being fetched: 1, 2 or 3
    logic [1:0]       opnd_sel;

    cpu_pkg::opcode_t opcode;
    cpu_pkg::opcode_t dec_opcode;
    cpu_pkg::field_t  cur_field;
    logic             cur_ind;
    cpu_pkg::field_t  tgt_field;
    logic             tgt_ind;
    cpu_pkg::addr_t   rdata_addr;
    cpu_pkg::addr_t   tgt_addr;

    assign opcode     = ir_reg[15:12];
    assign dec_opcode = mem_rdata[15:12];
    assign tgt_field  = ir_reg[10:8];
    assign tgt_ind    = ir_reg[11];
    assign rdata_addr = mem_rdata[cpu_pkg::ADDR_W-1:0];

    // indirect target address comes back from the read issued in S_TGT
    assign tgt_addr = tgt_ind ? rdata_addr : {3'b000, tgt_field};

    always_comb begin
        case (opnd_sel)
            2'd1: begin
                cur_field = ir_reg[10:8];
                cur_ind   = ir_reg[11];
            end
            2'd3: begin
                cur_field = ir_reg[2:0];
                cur_ind   = ir_reg[3];
            end
            default: begin
                cur_field = ir_reg[6:4];
                cur_ind   = ir_reg[7];
            end
        endcase
    end

    always_comb begin
        case (opcode)
            cpu_pkg::OP_SUB: alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_MUL: alu_op = cpu_pkg::ALU_MUL;
            default:         alu_op = cpu_pkg::ALU_ADD;
        endcase
    end

    assign alu_a     = src_a_reg;
    assign alu_b     = src_b_reg;
    assign mem_wdata = acc_reg;
    assign io_wdata  = src_a_reg;
    assign io_dir    = (opcode == cpu_pkg::OP_OUT);
    assign pc        = pc_reg;
    assign halted    = (state == S_STOP);

    always_comb begin
        state_next = state;
        mem_addr   = pc_reg;
        mem_we     = 1'b0;
        io_start   = 1'b0;
        case (state)
            S_START: state_next = S_FETCH;
            S_FETCH: state_next = S_DECODE;
            S_DECODE: begin
                case (dec_opcode)
                    cpu_pkg::OP_MOV,
                    cpu_pkg::OP_ADD,
                    cpu_pkg::OP_SUB,
                    cpu_pkg::OP_MUL,
                    cpu_pkg::OP_OUT:  state_next = S_OP_DIR;
                    cpu_pkg::OP_IN:   state_next = S_IO_START;
                    cpu_pkg::OP_STOP: state_next = S_STOP;
                    default:          state_next = S_FETCH;
                endcase
            end
            S_OP_DIR: begin
                mem_addr   = {3'b000, cur_field};
                state_next = cur_ind ? S_OP_IND : S_OP_CAP;
            end
            S_OP_IND: begin
                // pointer word arrived, read what it points at
                mem_addr   = rdata_addr;
                state_next = S_OP_CAP;
            end
            S_OP_CAP: begin
                if (opnd_sel == 2'd1) begin
                    state_next = S_IO_START;
                end else if (opnd_sel == 2'd2 && opcode != cpu_pkg::OP_MOV) begin
                    state_next = S_OP_DIR;
                end else begin
                    state_next = S_EXEC;
                end
            end
            S_EXEC: state_next = tgt_ind ? S_TGT : S_WB;
            S_IO_START: begin
                io_start   = 1'b1;
                state_next = S_IO_WAIT;
            end
            S_IO_WAIT: begin
                if (io_done) begin
                    if (io_dir) begin
                        state_next = S_FETCH;
                    end else begin
                        state_next = tgt_ind ? S_TGT : S_WB;
                    end
                end
            end
            S_TGT: begin
                mem_addr   = {3'b000, tgt_field};
                state_next = S_WB;
            end
            S_WB: begin
                mem_addr   = tgt_addr;
                mem_we     = 1'b1;
                state_next = S_FETCH;
            end
            S_STOP: state_next = S_STOP;
            default: state_next = S_START;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_START;
            pc_reg   <= '0;
            opnd_sel <= 2'd0;
        end else begin
            state <= state_next;
            case (state)
                S_START: pc_reg <= cpu_pkg::PC_START;
                S_FETCH: pc_reg <= pc_reg + cpu_pkg::addr_t'(1);
                S_DECODE: begin
                    // OUT reads operand 1, the rest start at operand 2
                    opnd_sel <= (dec_opcode == cpu_pkg::OP_OUT) ? 2'd1 : 2'd2;
                end
                S_OP_CAP: begin
                    if (opnd_sel == 2'd2) begin
                        opnd_sel <= 2'd3;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_DECODE: ir_reg <= mem_rdata;
            S_OP_CAP: begin
                if (opnd_sel == 2'd3) begin
                    src_b_reg <= mem_rdata;
                end else begin
                    src_a_reg <= mem_rdata;
                end
            end
            S_EXEC: acc_reg <= (opcode == cpu_pkg::OP_MOV) ? src_a_reg : alu_result;
            S_IO_WAIT: begin
                if (io_done && !io_dir) begin
                    acc_reg <= io_rdata;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== cpu/cpu_top.sv ====
// ####################
// CPU top: control unit, ALU and I/O port
// ####################
`default_nettype none

module cpu_top (
    input  wire                clk,
    input  wire                rst_n,
    input  wire cpu_pkg::word_t mem_rdata,
    input  wire                in_ack,
    input  wire cpu_pkg::word_t in_data,
    input  wire                out_ack,
    output cpu_pkg::addr_t     mem_addr,
    output cpu_pkg::word_t     mem_wdata,
    output logic               mem_we,
    output logic               in_req,
    output logic               out_req,
    output cpu_pkg::word_t     out_data,
    output cpu_pkg::addr_t     pc,
    output logic               halted
);

    cpu_pkg::alu_op_t alu_op;
    cpu_pkg::word_t   alu_a;
    cpu_pkg::word_t   alu_b;
    cpu_pkg::word_t   alu_result;

    logic             io_start;
    logic             io_dir;
    logic             io_done;
    cpu_pkg::word_t   io_wdata;
    cpu_pkg::word_t   io_rdata;

    cpu_control i_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .io_done    (io_done),
        .io_rdata   (io_rdata),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .io_start   (io_start),
        .io_dir     (io_dir),
        .io_wdata   (io_wdata),
        .pc         (pc),
        .halted     (halted)
    );

    alu i_alu (
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    io_port i_io (
        .clk      (clk),
        .rst_n    (rst_n),
        .io_start (io_start),
        .io_dir   (io_dir),
        .io_wdata (io_wdata),
        .in_ack   (in_ack),
        .in_data  (in_data),
        .out_ack  (out_ack),
        .io_done  (io_done),
        .io_rdata (io_rdata),
        .in_req   (in_req),
        .out_req  (out_req),
        .out_data (out_data)
    );

endmodule

`default_nettype wire

// ==== tb/cpu_checker.sv ====
// ####################
// reference ISA model and compare process
// ####################
`default_nettype none

module cpu_checker (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire logic [64*cpu_pkg::WORD_W-1:0]  init_image,
    input  wire logic [16*cpu_pkg::WORD_W-1:0]  in_image,
    input  wire cpu_pkg::addr_t                 mem_addr,
    input  wire cpu_pkg::word_t                 mem_wdata,
    input  wire                                 mem_we,
    input  wire                                 in_req,
    input  wire                                 in_ack,
    input  wire                                 out_req,
    input  wire                                 out_ack,
    input  wire cpu_pkg::word_t                 out_data,
    input  wire cpu_pkg::addr_t                 pc,
    input  wire                                 halted,
    output int                                  value_errors,
    output int                                  protocol_errors
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int EV_NONE  = 0;
    localparam int EV_WRITE = 1;
    localparam int EV_OUT   = 2;
    localparam int EV_STOP  = 3;

    cpu_pkg::word_t ref_mem [64];
    cpu_pkg::word_t ref_in [16];
    cpu_pkg::addr_t ref_pc;
    int             ref_in_idx;
    int             edges;
    logic           in_busy;
    logic           in_acked;
    logic           out_busy;
    logic           out_checked;
    cpu_pkg::word_t out_hold;
    logic           halt_seen;

    function automatic cpu_pkg::addr_t resolve(logic ind, cpu_pkg::field_t f);
        return ind ? ref_mem[f][cpu_pkg::ADDR_W-1:0] : cpu_pkg::addr_t'(f);
    endfunction

    // run the model up to its next visible event
    function automatic int ref_step(output cpu_pkg::addr_t ev_addr,
                                    output cpu_pkg::word_t ev_data);
        cpu_pkg::word_t ir;
        cpu_pkg::word_t b;
        cpu_pkg::word_t c;
        int             kind;
        int             n;
        kind    = EV_NONE;
        n       = 0;
        ev_addr = '0;
        ev_data = '0;
        while (kind == EV_NONE && n < 64) begin
            n++;
            ir     = ref_mem[ref_pc];
            ref_pc = ref_pc + 1'b1;
            b      = ref_mem[resolve(ir[7], ir[6:4])];
            c      = ref_mem[resolve(ir[3], ir[2:0])];
            kind   = EV_WRITE;
            case (ir[15:12])
                cpu_pkg::OP_MOV: ev_data = b;
                cpu_pkg::OP_ADD: ev_data = b + c;
                cpu_pkg::OP_SUB: ev_data = b - c;
                cpu_pkg::OP_MUL: ev_data = b * c;
                cpu_pkg::OP_IN: begin
                    ev_data    = ref_in[ref_in_idx % 16];
                    ref_in_idx = ref_in_idx + 1;
                end
                cpu_pkg::OP_OUT: begin
                    ev_data = ref_mem[resolve(ir[11], ir[10:8])];
                    kind    = EV_OUT;
                end
                cpu_pkg::OP_STOP: kind = EV_STOP;
                default: kind = EV_NONE;
            endcase
            if (kind == EV_WRITE) begin
                ev_addr          = resolve(ir[11], ir[10:8]);
                ref_mem[ev_addr] = ev_data;
            end
        end
        // park on STOP
        if (kind == EV_STOP) begin
            ref_pc = ref_pc - 1'b1;
        end
        return kind;
    endfunction

    function automatic string kind_name(int kind);
        case (kind)
            EV_WRITE: return "a memory write";
            EV_OUT:   return "an output word";
            EV_STOP:  return "halt";
            default:  return "nothing";
        endcase
    endfunction

    task automatic report_mismatch(string name, cpu_pkg::word_t exp, cpu_pkg::word_t act);
        $display("[ERROR] %0d ns: %s expected %h, got %h", $time, name, exp, act);
        value_errors++;
    endtask

    task automatic report_sequence(string seen, int kind);
        $display("%0d ns: DUT showed %s while the model expected %s",
                 $time, seen, kind_name(kind));
        value_errors++;
    endtask

    task automatic report_failure(string what);
        $display("%0d ns: %s", $time, what);
        protocol_errors++;
    endtask

    task automatic load_model();
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = init_image[i*cpu_pkg::WORD_W +: cpu_pkg::WORD_W];
        end
        for (int i = 0; i < 16; i++) begin
            ref_in[i] = in_image[i*cpu_pkg::WORD_W +: cpu_pkg::WORD_W];
        end
        ref_pc      = cpu_pkg::PC_START;
        ref_in_idx  = 0;
        in_busy     = 1'b0;
        in_acked    = 1'b0;
        out_busy    = 1'b0;
        out_checked = 1'b0;
        halt_seen   = 1'b0;
    endtask

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        edges           = 0;
        halt_seen       = 1'b0;
    end

    always @(posedge clk) begin
        cpu_pkg::addr_t exp_addr;
        cpu_pkg::word_t exp_data;
        int             kind;
        if (!rst_n) begin
            edges = 0;
        end else begin
            if (edges == 0) begin
                load_model();
                // first edge out of reset
                if (mem_we !== 1'b0 || in_req !== 1'b0 || out_req !== 1'b0 ||
                    halted !== 1'b0) begin
                    report_failure("control outputs not low after reset");
                end
            end
            edges++;
            // first fetch on the second edge after release
            if (edges == 2) begin
                if (mem_addr !== cpu_pkg::PC_START) begin
                    report_mismatch("mem_addr", cpu_pkg::PC_START, mem_addr);
                end
                if (pc !== cpu_pkg::PC_START) begin
                    report_mismatch("pc", cpu_pkg::PC_START, pc);
                end
            end
            if (halt_seen && (mem_we !== 1'b0 || in_req !== 1'b0 || out_req !== 1'b0)) begin
                report_failure("memory write or request after halt");
            end
            if (mem_we === 1'b1 && !halt_seen) begin
                kind = ref_step(exp_addr, exp_data);
                if (kind != EV_WRITE) begin
                    report_sequence("a memory write", kind);
                end else begin
                    if (mem_addr !== exp_addr) begin
                        report_mismatch("mem_addr", exp_addr, mem_addr);
                    end
                    if (mem_wdata !== exp_data) begin
                        report_mismatch("mem_wdata", exp_data, mem_wdata);
                    end
                end
            end
            if (in_req === 1'b1) begin
                in_busy = 1'b1;
                if (in_ack === 1'b1) begin
                    in_acked = 1'b1;
                end
            end else if (in_busy) begin
                if (!in_acked) begin
                    report_failure("in_req dropped before in_ack rose");
                end
                in_busy  = 1'b0;
                in_acked = 1'b0;
            end
            if (out_req === 1'b1) begin
                if (!out_busy) begin
                    out_busy    = 1'b1;
                    out_checked = 1'b0;
                    out_hold    = out_data;
                end else if (out_data !== out_hold) begin
                    report_mismatch("out_data", out_hold, out_data);
                end
                if (out_ack === 1'b1 && !out_checked) begin
                    out_checked = 1'b1;
                    kind = ref_step(exp_addr, exp_data);
                    if (kind != EV_OUT) begin
                        report_sequence("an output word", kind);
                    end else if (out_data !== exp_data) begin
                        report_mismatch("out_data", exp_data, out_data);
                    end
                end
            end else begin
                out_busy = 1'b0;
            end
            if (halted === 1'b1 && !halt_seen) begin
                halt_seen = 1'b1;
                kind = ref_step(exp_addr, exp_data);
                if (kind != EV_STOP) begin
                    report_sequence("halt", kind);
                end
            end else if (halt_seen && halted !== 1'b1) begin
                report_failure("halted dropped before the next reset");
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_cpu.sv ====
// ####################
// CPU testbench: clock, reset, memory model, program image, I/O partner
// ####################
`default_nettype none

module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS  = 64;
    localparam int IN_WORDS   = 16;
    localparam int HALT_LIMIT = 2000;
    localparam int ACK_LIMIT  = 50;

    logic           clk;
    logic           rst_n;
    cpu_pkg::word_t mem_rdata;
    logic           in_ack;
    cpu_pkg::word_t in_data;
    logic           out_ack;
    cpu_pkg::addr_t mem_addr;
    cpu_pkg::word_t mem_wdata;
    logic           mem_we;
    logic           in_req;
    logic           out_req;
    cpu_pkg::word_t out_data;
    cpu_pkg::addr_t pc;
    logic           halted;

    cpu_pkg::word_t mem [MEM_WORDS];
    cpu_pkg::word_t in_seq [IN_WORDS];
    logic [MEM_WORDS*cpu_pkg::WORD_W-1:0] init_image;
    logic [IN_WORDS*cpu_pkg::WORD_W-1:0]  in_image;
    cpu_pkg::addr_t prog_addr;
    integer         seed;
    int             in_idx;
    int             value_errors;
    int             protocol_errors;
    int             timeout_errors;

    cpu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .in_ack    (in_ack),
        .in_data   (in_data),
        .out_ack   (out_ack),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .in_req    (in_req),
        .out_req   (out_req),
        .out_data  (out_data),
        .pc        (pc),
        .halted    (halted)
    );

    cpu_checker i_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .init_image      (init_image),
        .in_image        (in_image),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_we          (mem_we),
        .in_req          (in_req),
        .in_ack          (in_ack),
        .out_req         (out_req),
        .out_ack         (out_ack),
        .out_data        (out_data),
        .pc              (pc),
        .halted          (halted),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors)
    );

    function automatic int random_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // write targets: direct 0..3, indirect through pointer cells 4..7
    function automatic cpu_pkg::field_t pick_target(logic ind);
        return cpu_pkg::field_t'(random_below(4) + (ind ? 4 : 0));
    endfunction

    task automatic emit(cpu_pkg::opcode_t op, logic ind1, cpu_pkg::field_t f1,
                        logic ind2, logic ind3);
        cpu_pkg::field_t f2;
        cpu_pkg::field_t f3;
        f2 = cpu_pkg::field_t'(random_below(8));
        f3 = cpu_pkg::field_t'(random_below(8));
        mem[prog_addr] = {op, ind1, f1, ind2, f2, ind3, f3};
        prog_addr = prog_addr + 1'b1;
    endtask

    task automatic build_image();
        cpu_pkg::opcode_t ops [6];
        cpu_pkg::opcode_t op;
        logic             ind1;
        logic             ind2;
        logic             ind3;
        ops = '{cpu_pkg::OP_MOV, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
                cpu_pkg::OP_MUL, cpu_pkg::OP_IN, cpu_pkg::OP_OUT};
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = cpu_pkg::word_t'(16'hC000 | (i << 6) | i);
        end
        // random data, then pointers back into it
        for (int i = 0; i < 4; i++) begin
            mem[i]     = cpu_pkg::word_t'($random(seed));
            mem[i + 4] = cpu_pkg::word_t'(random_below(4));
        end
        for (int i = 0; i < IN_WORDS; i++) begin
            in_seq[i] = cpu_pkg::word_t'($random(seed));
        end
        prog_addr = cpu_pkg::PC_START;
        for (int m = 0; m < 4; m++) begin
            emit(cpu_pkg::OP_MOV, m >= 2, pick_target(m >= 2), m % 2 == 1, 1'b0);
        end
        for (int k = 1; k < 4; k++) begin
            for (int m = 0; m < 2; m++) begin
                emit(ops[k], m == 1, pick_target(m == 1), m == 1, m == 1);
            end
        end
        emit(cpu_pkg::OP_IN, 1'b0, pick_target(1'b0), 1'b0, 1'b0);
        emit(cpu_pkg::OP_IN, 1'b1, pick_target(1'b1), 1'b0, 1'b0);
        emit(cpu_pkg::OP_OUT, 1'b0, cpu_pkg::field_t'(random_below(8)), 1'b0, 1'b0);
        emit(cpu_pkg::OP_OUT, 1'b1, cpu_pkg::field_t'(random_below(8)), 1'b0, 1'b0);
        for (int n = 0; n < 10; n++) begin
            op   = ops[random_below(6)];
            ind1 = random_below(2) == 1;
            ind2 = random_below(2) == 1;
            ind3 = random_below(2) == 1;
            if (op == cpu_pkg::OP_OUT) begin
                emit(op, ind1, cpu_pkg::field_t'(random_below(8)), ind2, ind3);
            end else begin
                emit(op, ind1, pick_target(ind1), ind2, ind3);
            end
        end
        emit(cpu_pkg::OP_STOP, 1'b0, 3'd0, 1'b0, 1'b0);
        for (int i = 0; i < MEM_WORDS; i++) begin
            init_image[i*cpu_pkg::WORD_W +: cpu_pkg::WORD_W] = mem[i];
        end
        for (int i = 0; i < IN_WORDS; i++) begin
            in_image[i*cpu_pkg::WORD_W +: cpu_pkg::WORD_W] = in_seq[i];
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // synchronous memory, one cycle read
    always @(posedge clk) begin
        cpu_pkg::addr_t rd_addr;
        cpu_pkg::word_t rd_word;
        rd_addr = mem_addr;
        rd_word = mem[rd_addr];
        if (mem_we === 1'b1) begin
            mem[rd_addr] = mem_wdata;
        end
        #2;
        mem_rdata = rd_word;
    end

    // partner for both channels, only one request is ever open
    initial begin : io_partner
        int delay;
        int cyc;
        forever begin
            @(posedge clk);
            if (in_req === 1'b1 || out_req === 1'b1) begin
                delay = random_below(6);
                repeat (delay) @(posedge clk);
                #2;
                if (in_req === 1'b1) begin
                    in_data = in_seq[in_idx % IN_WORDS];
                    in_idx  = in_idx + 1;
                    in_ack  = 1'b1;
                end else begin
                    out_ack = 1'b1;
                end
                cyc = 0;
                while ((in_req === 1'b1 || out_req === 1'b1) && cyc < ACK_LIMIT) begin
                    @(posedge clk);
                    cyc++;
                end
                if (cyc >= ACK_LIMIT) begin
                    $display("%0d ns: request never dropped after ack", $time);
                    timeout_errors++;
                end
                #2;
                in_ack  = 1'b0;
                out_ack = 1'b0;
            end
        end
    end

    initial begin
        int cyc;
        seed           = 82;
        rst_n          = 1'b0;
        mem_rdata      = '0;
        in_ack         = 1'b0;
        in_data        = '0;
        out_ack        = 1'b0;
        in_idx         = 0;
        timeout_errors = 0;
        build_image();
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        cyc = 0;
        while (halted !== 1'b1 && cyc < HALT_LIMIT) begin
            @(posedge clk);
            cyc++;
        end
        if (halted !== 1'b1) begin
            $display("%0d ns: halted never rose within %0d cycles", $time, HALT_LIMIT);
            timeout_errors++;
        end
        // quiet period after halt
        repeat (10) @(posedge clk);
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors == 0 && protocol_errors == 0 && timeout_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/cpu_pkg.sv
logic/alu.sv
logic/io_port.sv
cpu/cpu_control.sv
cpu/cpu_top.sv
tb/cpu_checker.sv
tb/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu_multicycle

sources:
  - common/cpu_pkg.sv
  - logic/alu.sv
  - logic/io_port.sv
  - cpu/cpu_control.sv
  - cpu/cpu_top.sv
  - target: test
    files:
      - tb/cpu_checker.sv
      - tb/tb_cpu.sv
